// ==== fp16_add.f ====
fp16_fmt_pkg.sv
fp16_rnd_pkg.sv
fp16_classify.sv
fp16_close_path.sv
fp16_far_path.sv
fp16_round_pack.sv
fp16_add.sv
tb_fp16_add.sv

// ==== Bender.yml ====
package:
  name: fp16_add

sources:
  - fp16_fmt_pkg.sv
  - fp16_rnd_pkg.sv
  - fp16_classify.sv
  - fp16_close_path.sv
  - fp16_far_path.sv
  - fp16_round_pack.sv
  - fp16_add.sv
  - target: simulation
    files:
      - tb_fp16_add.sv

// ==== tb_fp16_add.sv ====
`timescale 1ns/1ps

module tb_fp16_add;

	// Expected result and flags of one operation
	typedef struct packed {
		fp16_fmt_pkg::fp16_t       res;
		fp16_rnd_pkg::fp16_flags_t flags;
	} expect_t;

	logic                      clk;
	logic                      rst_n_i;
	logic                      valid_i;
	fp16_fmt_pkg::fp16_t       a_i;
	fp16_fmt_pkg::fp16_t       b_i;
	logic                      sub_i;
	fp16_rnd_pkg::rnd_mode_e   rm_i;
	logic                      valid_o;
	fp16_fmt_pkg::fp16_t       res_o;
	fp16_rnd_pkg::fp16_flags_t flags_o;

	// One entry per operation in flight, oldest first
	expect_t     exp_q[$];
	string       name_q[$];
	logic [31:0] rng_state;

	fp16_add i_fp16_add (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.valid_i (valid_i),
		.a_i     (a_i),
		.b_i     (b_i),
		.sub_i   (sub_i),
		.rm_i    (rm_i),
		.valid_o (valid_o),
		.res_o   (res_o),
		.flags_o (flags_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ========================================
	// Random numbers
	// ========================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Finite operand, exponent 31 folded into the subnormal range
	function automatic fp16_fmt_pkg::fp16_t rand_operand();
		logic [31:0]         r;
		fp16_fmt_pkg::fp16_t x;
		r = next_random();
		x = r[15:0];
		if (x.exp == 5'd31 || r[17:16] == 2'b00) begin
			x.exp = 5'd0;
		end
		return x;
	endfunction

	// ========================================
	// Reference model
	// ========================================
	// Exact value in units of 2^-24, sign not applied
	function automatic longint to_units(input fp16_fmt_pkg::fp16_t x);
		longint sig;
		int     e;
		sig = {x.exp != 5'd0, x.frac};
		e   = (x.exp == 5'd0) ? 1 : int'(x.exp);
		return sig << (e - 1);
	endfunction

	function automatic expect_t ref_add(input fp16_fmt_pkg::fp16_t a,
		input fp16_fmt_pkg::fp16_t b, input logic sub, input fp16_rnd_pkg::rnd_mode_e rm);
		expect_t r;
		logic    sb;
		logic    a_nan;
		logic    b_nan;
		logic    a_inf;
		logic    b_inf;
		logic    neg;
		logic    g;
		logic    s;
		logic    up;
		logic    to_zero;
		longint  sum;
		longint  mag;
		longint  sig;
		longint  rem;
		int      shift;
		int      e;
		r     = '0;
		sb    = b.sign ^ sub;
		a_nan = (a.exp == 5'd31) && (a.frac != 10'd0);
		b_nan = (b.exp == 5'd31) && (b.frac != 10'd0);
		a_inf = (a.exp == 5'd31) && (a.frac == 10'd0);
		b_inf = (b.exp == 5'd31) && (b.frac == 10'd0);
		// NaN inputs and inf - inf give the canonical NaN
		if (a_nan || b_nan || (a_inf && b_inf && (a.sign != sb))) begin
			r.res      = 16'h7E00;
			r.flags.nv = (a_nan && !a.frac[9]) || (b_nan && !b.frac[9]) || (a_inf && b_inf);
			return r;
		end
		if (a_inf || b_inf) begin
			r.res = {a_inf ? a.sign : sb, 15'h7C00};
			return r;
		end
		sum = a.sign ? -to_units(a) : to_units(a);
		sum = sb ? sum - to_units(b) : sum + to_units(b);
		// Exact zero, -0 only when rounding down or both negative
		if (sum == 0) begin
			r.res = {(rm == fp16_rnd_pkg::RDN) ? (a.sign | sb) : (a.sign & sb), 15'h0000};
			return r;
		end
		neg = (sum < 0);
		mag = neg ? -sum : sum;
		// Below 2^-13 the encoding is the magnitude itself, always exact
		if (mag < 2048) begin
			r.res = {neg, mag[14:0]};
			return r;
		end
		shift = 0;
		while ((mag >> shift) >= 2048) begin
			shift++;
		end
		sig = mag >> shift;
		rem = mag - (sig << shift);
		g   = rem[shift-1];
		s   = (rem & ((longint'(1) << (shift - 1)) - 1)) != 0;
		e   = shift + 1;
		case (rm)
			fp16_rnd_pkg::RNE: up = g && (sig[0] || s);
			fp16_rnd_pkg::RTZ: up = 1'b0;
			fp16_rnd_pkg::RDN: up = neg && (g || s);
			fp16_rnd_pkg::RUP: up = !neg && (g || s);
			default: up = g;
		endcase
		to_zero = (rm == fp16_rnd_pkg::RTZ) || (rm == fp16_rnd_pkg::RDN && !neg) ||
			(rm == fp16_rnd_pkg::RUP && neg);
		sig = sig + longint'(up);
		if (sig == 2048) begin
			sig = 1024;
			e++;
		end
		if (e >= 31) begin
			r.res      = to_zero ? {neg, 15'h7BFF} : {neg, 15'h7C00};
			r.flags.of = 1'b1;
			r.flags.nx = 1'b1;
		end else begin
			r.res      = {neg, 5'(e), sig[9:0]};
			r.flags.nx = g || s;
		end
		return r;
	endfunction

	// ========================================
	// Stimulus and checking helpers
	// ========================================
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic drive_op(input fp16_fmt_pkg::fp16_t a, input fp16_fmt_pkg::fp16_t b,
		input logic sub, input fp16_rnd_pkg::rnd_mode_e rm, input string name);
		@(negedge clk);
		a_i     = a;
		b_i     = b;
		sub_i   = sub;
		rm_i    = rm;
		valid_i = 1'b1;
		exp_q.push_back(ref_add(a, b, sub, rm));
		name_q.push_back($sformatf("%s a=%h b=%h sub=%0d rm=%0d", name, a, b, sub, rm));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			valid_i = 1'b0;
		end
	endtask

	task automatic drain_pipeline();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 20) begin
			@(negedge clk);
			valid_i = 1'b0;
			n++;
		end
		if (exp_q.size() != 0) begin
			stop_on_error("timeout while waiting for the last results");
		end
	endtask

	// One cycle latency, so at each edge at most the newest op is pending
	initial begin : compare
		expect_t want;
		string   tname;
		forever begin
			@(posedge clk);
			#1;
			if (exp_q.size() == 0) begin
				assert (valid_o === 1'b0)
					else stop_on_error("valid_o high with no operation in flight");
			end else begin
				assert (valid_o === 1'b1)
					else stop_on_error("valid_o not high one cycle after valid_i");
				want  = exp_q.pop_front();
				tname = name_q.pop_front();
				assert ({res_o, flags_o} === want)
					else stop_on_error($sformatf("error %s expected %h/%b actual %h/%b",
						tname, want.res, want.flags, res_o, flags_o));
			end
		end
	end

	// ========================================
	// Test sequence
	// ========================================
	initial begin : stimulus
		logic [31:0]             r;
		fp16_fmt_pkg::fp16_t     a;
		fp16_fmt_pkg::fp16_t     b;
		logic                    sub;
		fp16_rnd_pkg::rnd_mode_e rm;
		int                      i;
		int                      m;
		int                      s;
		rng_state = 32'd9;
		rst_n_i   = 1'b0;
		valid_i   = 1'b0;
		a_i       = '0;
		b_i       = '0;
		sub_i     = 1'b0;
		rm_i      = fp16_rnd_pkg::RNE;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		idle_cycles(3);

		// Same-sign normals, equal exponents often, so carries happen
		for (i = 0; i < 150; i++) begin
			r = next_random();
			a = rand_operand();
			b = rand_operand();
			if (a.exp == 5'd0) begin
				a.exp = 5'd15;
			end
			b.exp  = r[0] ? a.exp : ((b.exp == 5'd0) ? 5'd14 : b.exp);
			b.sign = a.sign;
			drive_op(a, b, 1'b0, fp16_rnd_pkg::RNE, "same_sign_rne");
		end

		// Close path, low fraction bits flipped for long cancellations
		for (i = 0; i < 150; i++) begin
			r = next_random();
			a = rand_operand();
			if (r[17]) begin
				a.exp = 5'(a.exp % 6);
			end
			b      = a;
			b.frac = a.frac ^ (r[9:0] >> r[13:10]);
			if (r[14] && a.exp < 5'd30) begin
				b.exp = a.exp + 5'd1;
			end else if (r[15] && a.exp > 5'd0) begin
				b.exp = a.exp - 5'd1;
			end
			sub    = r[16];
			b.sign = ~a.sign ^ sub;
			rm     = fp16_rnd_pkg::rnd_mode_e'(3'(r[31:20] % 5));
			drive_op(a, b, sub, rm, "close_path");
		end
		for (m = 0; m < 5; m++) begin
			a = rand_operand();
			drive_op(a, a, 1'b1, fp16_rnd_pkg::rnd_mode_e'(m), "exact_cancel");
		end

		// Any finite operands under every mode
		for (i = 0; i < 400; i++) begin
			r = next_random();
			a = rand_operand();
			b = rand_operand();
			drive_op(a, b, r[0], fp16_rnd_pkg::rnd_mode_e'(3'(r[12:4] % 5)), "random");
		end

		// Sums near the top of the range
		for (m = 0; m < 5; m++) begin
			rm = fp16_rnd_pkg::rnd_mode_e'(m);
			for (s = 0; s < 2; s++) begin
				a = {s[0], 15'h7BFF};
				drive_op(a, a, 1'b0, rm, "overflow");
				for (i = 0; i < 6; i++) begin
					r      = next_random();
					a      = {s[0], 5'd30, r[23:14]};
					b      = {s[0], 5'(18 + r[3:0] % 13), r[13:4]};
					sub    = r[24];
					b.sign = s[0] ^ sub;
					drive_op(a, b, sub, rm, "overflow");
				end
			end
		end

		// NaN, infinity and signed zero operands
		for (m = 0; m < 5; m++) begin
			rm = fp16_rnd_pkg::rnd_mode_e'(m);
			drive_op(16'h7E00, 16'h3C00, 1'b0, rm, "qnan");
			drive_op(16'h3C00, 16'hFE01, 1'b1, rm, "qnan");
			drive_op(16'h7C01, 16'h3C00, 1'b0, rm, "snan");
			drive_op(16'hC000, 16'h7D00, 1'b1, rm, "snan");
			drive_op(16'h7C00, 16'h7C00, 1'b1, rm, "inf_minus_inf");
			drive_op(16'hFC00, 16'h7C00, 1'b0, rm, "inf_minus_inf");
			drive_op(16'h7C00, 16'h7C00, 1'b0, rm, "inf_plus_inf");
			drive_op(16'h7C00, 16'h7BFF, 1'b1, rm, "inf_plus_finite");
			drive_op(16'h0001, 16'hFC00, 1'b0, rm, "inf_plus_finite");
			drive_op(16'h3C00, 16'h7C00, 1'b1, rm, "inf_plus_finite");
			drive_op(16'h0000, 16'h8000, 1'b0, rm, "signed_zero");
			drive_op(16'h8000, 16'h0000, 1'b1, rm, "signed_zero");
		end
		idle_cycles(2);

		// Gapped stream, gaps of zero to three idle cycles
		for (i = 0; i < 100; i++) begin
			r = next_random();
			a = rand_operand();
			b = rand_operand();
			drive_op(a, b, r[0], fp16_rnd_pkg::rnd_mode_e'(3'(r[10:8] % 5)), "stream_gap");
			idle_cycles(int'(r[13:12]));
		end

		drain_pipeline();
		idle_cycles(4);
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== fp16_add.sv ====
`timescale 1ns/1ps

module fp16_add (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      valid_i,
	input  fp16_fmt_pkg::fp16_t       a_i,
	input  fp16_fmt_pkg::fp16_t       b_i,
	input  logic                      sub_i,
	input  fp16_rnd_pkg::rnd_mode_e   rm_i,
	output logic                      valid_o,
	output fp16_fmt_pkg::fp16_t       res_o,
	output fp16_rnd_pkg::fp16_flags_t flags_o
);

	fp16_fmt_pkg::fp16_t     b_eff;
	logic                    close_sel;
	fp16_rnd_pkg::path_res_t close_res;
	fp16_rnd_pkg::path_res_t far_res;
	fp16_rnd_pkg::special_t  special;
	logic                    sign_large;
	fp16_rnd_pkg::s1_reg_t   s1_d;
	fp16_rnd_pkg::s1_reg_t   s1_q;

	// ========================================
	// Stage 0
	// ========================================
	// Subtraction is addition with b negated
	assign b_eff = {b_i.sign ^ sub_i, b_i.exp, b_i.frac};

	fp16_classify i_classify (
		.a_i       (a_i),
		.b_i       (b_eff),
		.rm_i      (rm_i),
		.special_o (special)
	);

	fp16_close_path i_close_path (
		.a_i         (a_i),
		.b_i         (b_eff),
		.close_sel_o (close_sel),
		.res_o       (close_res)
	);

	fp16_far_path i_far_path (
		.a_i   (a_i),
		.b_i   (b_eff),
		.res_o (far_res)
	);

	// Result carries the sign of the larger magnitude
	assign sign_large = ({a_i.exp, a_i.frac} >= {b_i.exp, b_i.frac}) ? a_i.sign : b_eff.sign;

	assign s1_d.res  = close_sel ? close_res : far_res;
	assign s1_d.spec = special;
	assign s1_d.sign = sign_large;
	assign s1_d.rm   = rm_i;

	// ========================================
	// Stage register and stage 1
	// ========================================
	always_ff @(posedge clk) begin
		if (valid_i) begin
			s1_q <= s1_d;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	fp16_round_pack i_round_pack (
		.s1_i    (s1_q),
		.res_o   (res_o),
		.flags_o (flags_o)
	);

	valid_known_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		!$isunknown(valid_o))
		else $error("valid_o unknown after reset");

	// A valid output came through both stages fully defined
	res_known_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		valid_o |-> !$isunknown({res_o, flags_o}))
		else $error("result or flags unknown while valid_o is high");

endmodule

// ==== fp16_round_pack.sv ====
`timescale 1ns/1ps

module fp16_round_pack (
	input  fp16_rnd_pkg::s1_reg_t     s1_i,
	output fp16_fmt_pkg::fp16_t       res_o,
	output fp16_rnd_pkg::fp16_flags_t flags_o
);

	logic                    gs;
	logic                    round_up;
	logic                    to_zero;
	logic [11:0]             rounded;
	fp16_fmt_pkg::fp16_exp_t exp_base;
	logic [5:0]              exp_out;
	logic                    overflow;
	logic                    special;
	fp16_fmt_pkg::fp16_t     normal_res;
	fp16_fmt_pkg::fp16_t     overflow_res;
	fp16_fmt_pkg::fp16_t     special_res;

	assign gs = s1_i.res.guard | s1_i.res.sticky;

	// ========================================
	// Rounding decision
	// ========================================
	// RDN and RUP turn into toward zero or away from zero by the sign
	always_comb begin
		round_up = 1'b0;
		to_zero  = 1'b0;
		case (s1_i.rm)
			fp16_rnd_pkg::RNE: round_up = s1_i.res.guard & (s1_i.res.sig[0] | s1_i.res.sticky);
			fp16_rnd_pkg::RTZ: to_zero = 1'b1;
			fp16_rnd_pkg::RDN: begin
				round_up = s1_i.sign & gs;
				to_zero  = ~s1_i.sign;
			end
			fp16_rnd_pkg::RUP: begin
				round_up = ~s1_i.sign & gs;
				to_zero  = s1_i.sign;
			end
			fp16_rnd_pkg::RMM: round_up = s1_i.res.guard;
			default: to_zero = 1'b1;
		endcase
	end

	assign rounded = {1'b0, s1_i.res.sig} + {11'b0, round_up};

	// Subnormal that reaches 1.0 becomes exponent 1
	assign exp_base = (s1_i.res.exp == '0) ? {4'b0, |rounded[11:10]} : s1_i.res.exp;
	// Carry from the add path and carry out of rounding both step the exponent
	assign exp_out  = {1'b0, exp_base} + {5'b0, s1_i.res.ovf} + {5'b0, rounded[11]};
	assign overflow = (exp_out >= 6'd31);

	// ========================================
	// Result select
	// ========================================
	// After a rounding carry the fraction bits are all zero anyway
	assign normal_res   = {s1_i.sign, exp_out[4:0], rounded[9:0]};
	// Largest finite value when rounding toward zero
	assign overflow_res = to_zero ? {s1_i.sign, 5'd30, 10'h3FF} :
		{s1_i.sign, fp16_fmt_pkg::EXP_MAX, 10'h000};

	assign special = s1_i.spec.nan | s1_i.spec.inf | s1_i.spec.exact_zero;

	always_comb begin
		if (s1_i.spec.nan)
			special_res = fp16_fmt_pkg::FP16_QNAN;
		else if (s1_i.spec.inf)
			special_res = {s1_i.spec.sign, fp16_fmt_pkg::EXP_MAX, 10'h000};
		else
			special_res = {s1_i.spec.sign, 15'h0000};
	end

	// Special beats overflow beats normal
	assign res_o = special ? special_res : (overflow ? overflow_res : normal_res);

	assign flags_o.nv = s1_i.spec.nv;
	assign flags_o.of = overflow & ~special;
	assign flags_o.nx = (gs | overflow) & ~special;

	// Classification never marks both
	nan_inf_excl_a: assert final ($isunknown(s1_i.spec) ||
		!(s1_i.spec.nan && s1_i.spec.inf))
		else $error("round_pack: nan and inf both set");

endmodule

// ==== fp16_far_path.sv ====
`timescale 1ns/1ps

module fp16_far_path (
	input  fp16_fmt_pkg::fp16_t     a_i,
	input  fp16_fmt_pkg::fp16_t     b_i,
	output fp16_rnd_pkg::path_res_t res_o
);

	fp16_fmt_pkg::fp16_exp_t ea;
	fp16_fmt_pkg::fp16_exp_t eb;
	logic                    eff_sub;
	logic                    a_big;
	fp16_fmt_pkg::fp16_exp_t exp_large;
	fp16_fmt_pkg::fp16_sig_t sig_large;
	fp16_fmt_pkg::fp16_sig_t sig_small;
	logic [4:0]              exp_diff;
	logic [3:0]              shamt;
	logic [25:0]             small_wide;
	logic [12:0]             op_large;
	logic [12:0]             op_small;
	logic                    lost_sticky;
	logic [13:0]             sum;
	logic [13:0]             raw;

	// Subnormals sit at the scale of exponent 1
	assign ea = (a_i.exp == '0) ? 5'd1 : a_i.exp;
	assign eb = (b_i.exp == '0) ? 5'd1 : b_i.exp;

	assign eff_sub   = a_i.sign ^ b_i.sign;
	assign a_big     = (ea >= eb);
	// Raw exponent so that two subnormals stay at exponent 0
	assign exp_large = a_big ? a_i.exp : b_i.exp;
	assign sig_large = a_big ? {a_i.exp != '0, a_i.frac} : {b_i.exp != '0, b_i.frac};
	assign sig_small = a_big ? {b_i.exp != '0, b_i.frac} : {a_i.exp != '0, a_i.frac};
	assign exp_diff  = a_big ? ea - eb : eb - ea;

	// ========================================
	// Alignment
	// ========================================
	// Beyond 15 everything is already below the kept bits
	assign shamt = (exp_diff > 5'd15) ? 4'd15 : exp_diff[3:0];

	// Upper half keeps sig, guard and round, lower half collects lost bits
	assign small_wide  = {sig_small, 2'b00, 13'b0} >> shamt;
	assign op_small    = small_wide[25:13];
	assign lost_sticky = |small_wide[12:0];
	assign op_large    = {sig_large, 2'b00};

	// ========================================
	// Add / subtract
	// ========================================
	// Subtract as L + ~S + 1, the carry in is dropped when bits were lost
	// so the sum is the floor and sticky still marks the remainder
	assign sum = {1'b0, op_large} + {1'b0, eff_sub ? ~op_small : op_small} +
		{13'b0, eff_sub & ~lost_sticky};
	// Top carry of a subtraction is the two's complement artifact
	assign raw = {sum[13] & ~eff_sub, sum[12:0]};

	always_comb begin
		if (raw[13]) begin
			// Sum reached 2.0, keep it shifted by one
			res_o.exp    = exp_large;
			res_o.sig    = raw[13:3];
			res_o.ovf    = 1'b1;
			res_o.guard  = raw[2];
			res_o.sticky = |raw[1:0] | lost_sticky;
		end else if (raw[12] || !eff_sub) begin
			// Already in [1.0, 2.0), or a subnormal sum
			res_o.exp    = exp_large;
			res_o.sig    = raw[12:2];
			res_o.ovf    = 1'b0;
			res_o.guard  = raw[1];
			res_o.sticky = raw[0] | lost_sticky;
		end else begin
			// Subtraction lost its top bit, at most one for a gap of two or more
			res_o.exp    = exp_large - 5'd1;
			res_o.sig    = raw[11:1];
			res_o.ovf    = 1'b0;
			res_o.guard  = raw[0];
			res_o.sticky = lost_sticky;
		end
	end

endmodule

// ==== fp16_close_path.sv ====
`timescale 1ns/1ps

module fp16_close_path (
	input  fp16_fmt_pkg::fp16_t     a_i,
	input  fp16_fmt_pkg::fp16_t     b_i,
	output logic                    close_sel_o,
	output fp16_rnd_pkg::path_res_t res_o
);

	// Effective exponents, subnormals count as exponent 1
	fp16_fmt_pkg::fp16_exp_t ea;
	fp16_fmt_pkg::fp16_exp_t eb;
	logic                    eff_sub;
	logic                    a_ge_b;
	logic                    exp_eq;
	logic                    exp_off1;
	fp16_fmt_pkg::fp16_exp_t exp_large;
	fp16_fmt_pkg::fp16_sig_t sig_large;
	fp16_fmt_pkg::fp16_sig_t sig_small;
	logic [11:0]             op_large;
	logic [11:0]             op_small;
	logic [11:0]             diff;
	logic [3:0]              lzc;
	logic                    limited;
	logic [4:0]              shamt;
	logic [11:0]             norm;

	// Leading zeros of the 12-bit difference, 12 for zero
	function automatic logic [3:0] lzc12(input logic [11:0] v);
		logic [3:0] cnt;
		logic       found;
		cnt   = 4'd12;
		found = 1'b0;
		for (int i = 11; i >= 0; i--) begin
			if (!found && v[i]) begin
				cnt   = 4'(11 - i);
				found = 1'b1;
			end
		end
		return cnt;
	endfunction

	assign ea = (a_i.exp == '0) ? 5'd1 : a_i.exp;
	assign eb = (b_i.exp == '0) ? 5'd1 : b_i.exp;

	// ========================================
	// Path select
	// ========================================
	assign eff_sub     = a_i.sign ^ b_i.sign;
	assign exp_eq      = (ea == eb);
	assign exp_off1    = (ea == eb + 5'd1) || (eb == ea + 5'd1);
	assign close_sel_o = eff_sub && (exp_eq || exp_off1);

	// Magnitude order, the bit pattern orders like the value
	assign a_ge_b    = ({a_i.exp, a_i.frac} >= {b_i.exp, b_i.frac});
	assign exp_large = a_ge_b ? ea : eb;
	assign sig_large = a_ge_b ? {a_i.exp != '0, a_i.frac} : {b_i.exp != '0, b_i.frac};
	assign sig_small = a_ge_b ? {b_i.exp != '0, b_i.frac} : {a_i.exp != '0, a_i.frac};

	// One extra low bit catches the bit lost by the 1-bit alignment
	assign op_large = {sig_large, 1'b0};
	assign op_small = exp_eq ? {sig_small, 1'b0} : {1'b0, sig_small};
	assign diff     = op_large - op_small;

	// ========================================
	// Normalize
	// ========================================
	assign lzc = lzc12(diff);
	// Stop at exponent 1, result is then subnormal
	// A zero difference lands at exponent 0 as well
	assign limited = (diff == '0) || ({1'b0, lzc} > exp_large - 5'd1);
	assign shamt   = limited ? exp_large - 5'd1 : {1'b0, lzc};
	assign norm    = diff << shamt;

	assign res_o.exp    = limited ? '0 : exp_large - shamt;
	assign res_o.sig    = norm[11:1];
	// Only an unshifted 1-bit alignment leaves a guard bit
	assign res_o.guard  = norm[0];
	assign res_o.sticky = 1'b0;
	// A difference never reaches 2.0
	assign res_o.ovf    = 1'b0;

	// Count and exponent limit agree on normalization
	close_norm_a: assert final ($isunknown({close_sel_o, res_o}) || !close_sel_o ||
		(res_o.exp == '0) || res_o.sig[10])
		else $error("close path: normal exponent with top bit clear");

endmodule

// ==== fp16_classify.sv ====
`timescale 1ns/1ps

module fp16_classify (
	input  fp16_fmt_pkg::fp16_t      a_i,
	input  fp16_fmt_pkg::fp16_t      b_i,
	input  fp16_rnd_pkg::rnd_mode_e  rm_i,
	output fp16_rnd_pkg::special_t   special_o
);

	logic a_zero;
	logic b_zero;
	logic a_inf;
	logic b_inf;
	logic a_snan;
	logic b_snan;
	logic a_nan;
	logic b_nan;
	logic eff_sub;
	logic mag_eq;
	logic inf_cancel;
	logic zero_sign;

	// Per-operand classes
	assign a_zero = (a_i.exp == '0) && (a_i.frac == '0);
	assign b_zero = (b_i.exp == '0) && (b_i.frac == '0);
	assign a_inf  = (a_i.exp == fp16_fmt_pkg::EXP_MAX) && (a_i.frac == '0);
	assign b_inf  = (b_i.exp == fp16_fmt_pkg::EXP_MAX) && (b_i.frac == '0);
	assign a_nan  = (a_i.exp == fp16_fmt_pkg::EXP_MAX) && (a_i.frac != '0);
	assign b_nan  = (b_i.exp == fp16_fmt_pkg::EXP_MAX) && (b_i.frac != '0);
	// Signaling when the quiet bit is clear
	assign a_snan = a_nan && !a_i.frac[9];
	assign b_snan = b_nan && !b_i.frac[9];

	// b's sign is already the effective one
	assign eff_sub    = a_i.sign ^ b_i.sign;
	assign mag_eq     = ({a_i.exp, a_i.frac} == {b_i.exp, b_i.frac});
	// inf - inf has no answer
	assign inf_cancel = a_inf && b_inf && eff_sub;

	// x - x is +0, except -0 when rounding down
	// Two zeros of one sign keep that sign under any mode
	assign zero_sign = (rm_i == fp16_rnd_pkg::RDN) ? (a_i.sign | b_i.sign) :
		(a_i.sign & b_i.sign);

	assign special_o.nan        = a_nan || b_nan || inf_cancel;
	assign special_o.nv         = a_snan || b_snan || inf_cancel;
	assign special_o.inf        = (a_inf || b_inf) && !special_o.nan;
	assign special_o.exact_zero = !(a_nan || b_nan || a_inf || b_inf) &&
		((a_zero && b_zero) || (mag_eq && eff_sub));
	// Infinity takes the sign of the infinite operand
	assign special_o.sign = special_o.exact_zero ? zero_sign :
		(a_inf ? a_i.sign : b_i.sign);

endmodule

// ==== fp16_rnd_pkg.sv ====
package fp16_rnd_pkg;

	// RISC-V rounding mode encoding
	typedef enum logic [2:0] {
		RNE = 3'd0,
		RTZ = 3'd1,
		RDN = 3'd2,
		RUP = 3'd3,
		RMM = 3'd4
	} rnd_mode_e;

	// Exception flags, ordered as in fflags minus dz and uf
	typedef struct packed {
		logic nv;
		logic of;
		logic nx;
	} fp16_flags_t;

	// Unrounded result of one add path
	// exp 0 means the significand sits at the scale of exponent 1
	typedef struct packed {
		fp16_fmt_pkg::fp16_exp_t exp;
		fp16_fmt_pkg::fp16_sig_t sig;
		// Raw sum reached 2.0, sig already holds it shifted right by one
		logic                    ovf;
		logic                    guard;
		logic                    sticky;
	} path_res_t;

	// Outcome of the operand classification
	typedef struct packed {
		logic nan;
		logic inf;
		logic exact_zero;
		logic nv;
		// Sign of the infinity or of the exact zero
		logic sign;
	} special_t;

	// Stage register between alignment/add and rounding
	typedef struct packed {
		path_res_t res;
		special_t  spec;
		logic      sign;
		rnd_mode_e rm;
	} s1_reg_t;

endpackage

// ==== fp16_fmt_pkg.sv ====
package fp16_fmt_pkg;

	// ========================================
	// Binary16 field layout
	// ========================================

	// Field widths
	localparam int EXP_W  = 5;
	localparam int FRAC_W = 10;
	// Hidden bit plus stored fraction
	localparam int SIG_W  = FRAC_W + 1;

	// Biased exponent
	typedef logic [EXP_W-1:0]  fp16_exp_t;
	// Stored fraction, hidden bit not included
	typedef logic [FRAC_W-1:0] fp16_frac_t;
	// Significand with the hidden bit on top
	typedef logic [SIG_W-1:0]  fp16_sig_t;

	// Operand as it sits on the bus, sign in bit 15
	typedef struct packed {
		logic       sign;
		fp16_exp_t  exp;
		fp16_frac_t frac;
	} fp16_t;

	// ========================================
	// Special encodings
	// ========================================

	// All-ones exponent marks infinity and NaN
	localparam fp16_exp_t EXP_MAX = 5'd31;

	// Canonical quiet NaN, positive, only the quiet bit set
	localparam fp16_t FP16_QNAN = 16'h7E00;

endpackage
